/* rtl/lsu_pkg.sv */
/*
 * lsu package
 * operation codes, AXI response codes and the widths and memory
 * depth shared by the load/store unit and its AXI4-Lite memory
 */
package lsu_pkg;

	// datapath widths
	localparam int DATA_W = 32;
	localparam int ADDR_W = 32;
	localparam int STRB_W = DATA_W / 8;
	localparam int REG_W  = 5;

	// slave memory depth in words
	localparam int MEM_WORDS = 256;
	localparam int MEM_IDX_W = $clog2(MEM_WORDS);

	// LFSR width for the slave wait states
	localparam int LFSR_W = 4;

	typedef enum logic [3:0] {
		OP_NONE = 4'd0,
		OP_LB   = 4'd1,
		OP_LH   = 4'd2,
		OP_LW   = 4'd3,
		OP_LBU  = 4'd4,
		OP_LHU  = 4'd5,
		OP_SB   = 4'd6,
		OP_SH   = 4'd7,
		OP_SW   = 4'd8
	} mem_op_e;

	// only the two codes this system produces
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} resp_e;

	function automatic logic op_is_load(mem_op_e op);
		return op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
	endfunction

	function automatic logic op_is_store(mem_op_e op);
		return op inside {OP_SB, OP_SH, OP_SW};
	endfunction

	function automatic logic op_is_half(mem_op_e op);
		return op inside {OP_LH, OP_LHU, OP_SH};
	endfunction

	function automatic logic op_is_word(mem_op_e op);
		return op inside {OP_LW, OP_SW};
	endfunction

endpackage

/* rtl/mem_align.sv */
/*
 * memory lane aligner
 * moves store bytes onto their byte lanes with matching strobes,
 * and picks load bytes off their lanes with sign or zero extension
 */
`timescale 1ns/100ps

module mem_align (
	input  lsu_pkg::mem_op_e                op_i,
	input  logic [1:0]                      addr_lo_i,
	input  logic [lsu_pkg::DATA_W-1:0]      store_data_i,
	input  logic [lsu_pkg::DATA_W-1:0]      load_raw_i,
	output logic [lsu_pkg::DATA_W-1:0]      store_data_o,
	output logic [lsu_pkg::STRB_W-1:0]      store_strb_o,
	output logic [lsu_pkg::DATA_W-1:0]      load_data_o
);
	import lsu_pkg::*;

	logic [DATA_W-1:0] lane_data;

	// store side, bytes copied to every lane and the strobe picks one
	always_comb begin
		case (op_i)
			OP_SB: begin
				store_data_o = {4{store_data_i[7:0]}};
				store_strb_o = 4'b0001 << addr_lo_i;
			end
			OP_SH: begin
				store_data_o = {2{store_data_i[15:0]}};
				store_strb_o = 4'b0011 << {addr_lo_i[1], 1'b0};
			end
			OP_SW: begin
				store_data_o = store_data_i;
				store_strb_o = 4'b1111;
			end
			default: begin
				store_data_o = '0;
				store_strb_o = '0;
			end
		endcase
	end

	// load side, addressed lane down to bit 0
	assign lane_data = load_raw_i >> {addr_lo_i, 3'b000};

	always_comb begin
		case (op_i)
			OP_LB:   load_data_o = {{24{lane_data[7]}}, lane_data[7:0]};
			OP_LH:   load_data_o = {{16{lane_data[15]}}, lane_data[15:0]};
			OP_LW:   load_data_o = lane_data;
			OP_LBU:  load_data_o = {24'd0, lane_data[7:0]};
			OP_LHU:  load_data_o = {16'd0, lane_data[15:0]};
			default: load_data_o = '0;
		endcase
	end

	// misaligned accesses are not supported by the unit
	always_comb begin
		if (op_is_half(op_i)) begin
			assert (addr_lo_i[0] == 1'b0)
			else $error("misaligned halfword access, addr_lo %0d", addr_lo_i);
		end
		if (op_is_word(op_i)) begin
			assert (addr_lo_i == 2'b00)
			else $error("misaligned word access, addr_lo %0d", addr_lo_i);
		end
	end

endmodule

/* rtl/lsu_ctrl.sv */
/*
 * load/store controller
 * takes one request at a time, runs it over AXI4-Lite as master
 * and returns a single-cycle result for writeback
 */
`timescale 1ns/100ps

module lsu_ctrl (
	input  logic                            clk,
	input  logic                            rstn,
	input  logic                            req_valid_i,
	input  lsu_pkg::mem_op_e                req_op_i,
	input  logic [lsu_pkg::ADDR_W-1:0]      req_addr_i,
	input  logic [lsu_pkg::DATA_W-1:0]      req_wdata_i,
	input  logic [lsu_pkg::REG_W-1:0]       req_rd_i,
	output logic                            req_ready_o,
	output logic [lsu_pkg::ADDR_W-1:0]      ar_addr_o,
	output logic                            ar_valid_o,
	input  logic                            ar_ready_i,
	input  logic [lsu_pkg::DATA_W-1:0]      r_data_i,
	input  lsu_pkg::resp_e                  r_resp_i,
	input  logic                            r_valid_i,
	output logic                            r_ready_o,
	output logic [lsu_pkg::ADDR_W-1:0]      aw_addr_o,
	output logic                            aw_valid_o,
	input  logic                            aw_ready_i,
	output logic [lsu_pkg::DATA_W-1:0]      w_data_o,
	output logic [lsu_pkg::STRB_W-1:0]      w_strb_o,
	output logic                            w_valid_o,
	input  logic                            w_ready_i,
	input  lsu_pkg::resp_e                  b_resp_i,
	input  logic                            b_valid_i,
	output logic                            b_ready_o,
	output logic                            resp_valid_o,
	output logic [lsu_pkg::REG_W-1:0]       resp_rd_o,
	output logic [lsu_pkg::DATA_W-1:0]      resp_data_o,
	output logic                            resp_err_o
);
	import lsu_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_ADDR, S_RESP, S_DONE} state_e;

	state_e            state_q, state_d;
	mem_op_e           op_q;
	logic [ADDR_W-1:0] addr_q;
	logic [DATA_W-1:0] wdata_q;
	logic [DATA_W-1:0] rdata_q;
	logic [REG_W-1:0]  rd_q;
	logic              aw_done_q, w_done_q, err_q;
	logic              accept, ar_hs, r_hs, aw_hs, w_hs, b_hs;
	logic              is_load, is_store, wr_addr_ok, wr_data_ok;
	logic [DATA_W-1:0] load_data;

	assign is_load  = op_is_load(op_q);
	assign is_store = op_is_store(op_q);

	assign req_ready_o = (state_q == S_IDLE);
	assign accept      = req_valid_i & req_ready_o;

	// AW and W drop independently once their beat has gone
	assign ar_valid_o = (state_q == S_ADDR) & is_load;
	assign aw_valid_o = (state_q == S_ADDR) & is_store & ~aw_done_q;
	assign w_valid_o  = (state_q == S_ADDR) & is_store & ~w_done_q;
	assign r_ready_o  = (state_q == S_RESP);
	assign b_ready_o  = (state_q == S_RESP);

	assign ar_hs = ar_valid_o & ar_ready_i;
	assign aw_hs = aw_valid_o & aw_ready_i;
	assign w_hs  = w_valid_o & w_ready_i;
	assign r_hs  = r_valid_i & r_ready_o;
	assign b_hs  = b_valid_i & b_ready_o;

	assign wr_addr_ok = aw_done_q | aw_hs;
	assign wr_data_ok = w_done_q | w_hs;

	assign ar_addr_o = addr_q;
	assign aw_addr_o = addr_q;

	mem_align u_mem_align (
		.op_i         (op_q),
		.addr_lo_i    (addr_q[1:0]),
		.store_data_i (wdata_q),
		.load_raw_i   (rdata_q),
		.store_data_o (w_data_o),
		.store_strb_o (w_strb_o),
		.load_data_o  (load_data)
	);

	always_comb begin
		state_d = state_q;
		case (state_q)
			S_IDLE: begin
				if (accept)
					state_d = (req_op_i == OP_NONE) ? S_DONE : S_ADDR;
			end
			S_ADDR: begin
				if (is_load ? ar_hs : (wr_addr_ok & wr_data_ok))
					state_d = S_RESP;
			end
			S_RESP: begin
				if (is_load ? r_hs : b_hs)
					state_d = S_DONE;
			end
			default: state_d = S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rstn) begin
			state_q   <= S_IDLE;
			op_q      <= OP_NONE;
			aw_done_q <= 1'b0;
			w_done_q  <= 1'b0;
			err_q     <= 1'b0;
		end else begin
			state_q <= state_d;
			if (accept) begin
				op_q  <= req_op_i;
				err_q <= 1'b0;
			end
			// done flags live only while in ADDR
			aw_done_q <= (state_d == S_ADDR) & wr_addr_ok;
			w_done_q  <= (state_d == S_ADDR) & wr_data_ok;
			if (r_hs)
				err_q <= (r_resp_i == RESP_SLVERR);
			else if (b_hs)
				err_q <= (b_resp_i == RESP_SLVERR);
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q  <= req_addr_i;
			wdata_q <= req_wdata_i;
			rd_q    <= req_rd_i;
		end
		if (r_hs)
			rdata_q <= r_data_i;
	end

	// result for writeback
	assign resp_valid_o = (state_q == S_DONE);
	assign resp_rd_o    = rd_q;
	assign resp_err_o   = err_q;

	always_comb begin
		if (is_load)
			resp_data_o = err_q ? '0 : load_data;
		else if (is_store)
			resp_data_o = '0;
		else
			resp_data_o = addr_q;
	end

	// master valids stay up with a steady payload until accepted
	ar_hold: assert property (@(posedge clk) disable iff (rstn)
		ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o));
	aw_hold: assert property (@(posedge clk) disable iff (rstn)
		aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_addr_o));
	w_hold: assert property (@(posedge clk) disable iff (rstn)
		w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_data_o) && $stable(w_strb_o));
	// slave responses only show up while the controller waits in RESP
	resp_in_wait: assert property (@(posedge clk) disable iff (rstn)
		(r_valid_i || b_valid_i) |-> (state_q == S_RESP));

endmodule

/* rtl/axi_sram.sv */
/*
 * AXI4-Lite word memory
 * slave side with pseudo-random wait states on AR, AW and W,
 * strobed writes and SLVERR outside the memory range
 */
`timescale 1ns/100ps

module axi_sram (
	input  logic                            clk,
	input  logic                            rstn,
	input  logic [lsu_pkg::ADDR_W-1:0]      ar_addr_i,
	input  logic                            ar_valid_i,
	output logic                            ar_ready_o,
	output logic [lsu_pkg::DATA_W-1:0]      r_data_o,
	output lsu_pkg::resp_e                  r_resp_o,
	output logic                            r_valid_o,
	input  logic                            r_ready_i,
	input  logic [lsu_pkg::ADDR_W-1:0]      aw_addr_i,
	input  logic                            aw_valid_i,
	output logic                            aw_ready_o,
	input  logic [lsu_pkg::DATA_W-1:0]      w_data_i,
	input  logic [lsu_pkg::STRB_W-1:0]      w_strb_i,
	input  logic                            w_valid_i,
	output logic                            w_ready_o,
	output lsu_pkg::resp_e                  b_resp_o,
	output logic                            b_valid_o,
	input  logic                            b_ready_i
);
	import lsu_pkg::*;

	logic [DATA_W-1:0] mem [MEM_WORDS];
	logic [LFSR_W-1:0] lfsr_q;
	logic [1:0]        wait_q [3];
	logic [2:0]        ch_valid, ch_open, ch_ready, ch_hs;
	logic              aw_got_q, w_got_q, r_valid_q, b_valid_q;
	logic [ADDR_W-1:0] aw_addr_q;
	logic [DATA_W-1:0] w_data_q, r_data_q;
	logic [STRB_W-1:0] w_strb_q;
	resp_e             r_resp_q, b_resp_q;
	logic              rd_in_range, wr_in_range, do_write;

	// word index must fall below MEM_WORDS
	assign rd_in_range = (ar_addr_i[ADDR_W-1:2] < MEM_WORDS);
	assign wr_in_range = (aw_addr_q[ADDR_W-1:2] < MEM_WORDS);
	assign do_write    = aw_got_q & w_got_q;

	// free running x^4 + x^3 + 1 LFSR
	always_ff @(posedge clk) begin
		if (rstn)
			lfsr_q <= 4'd1;
		else
			lfsr_q <= {lfsr_q[2:0], lfsr_q[3] ^ lfsr_q[2]};
	end

	// channel 0 is AR, 1 is AW and 2 is W
	assign ch_valid = {w_valid_i, aw_valid_i, ar_valid_i};
	assign ch_open  = {~w_got_q & ~b_valid_q, ~aw_got_q & ~b_valid_q, ~r_valid_q};

	for (genvar i = 0; i < 3; i++) begin : g_wait
		assign ch_ready[i] = ch_open[i] & (wait_q[i] == 2'd0);
		assign ch_hs[i]    = ch_valid[i] & ch_ready[i];

		// reload 0..3 wait cycles after every accepted beat
		always_ff @(posedge clk) begin
			if (rstn)
				wait_q[i] <= 2'd0;
			else if (ch_hs[i])
				wait_q[i] <= lfsr_q[i +: 2];
			else if (ch_valid[i] && wait_q[i] != 2'd0)
				wait_q[i] <= wait_q[i] - 2'd1;
		end
	end

	assign ar_ready_o = ch_ready[0];
	assign aw_ready_o = ch_ready[1];
	assign w_ready_o  = ch_ready[2];

	always_ff @(posedge clk) begin
		if (rstn) begin
			aw_got_q  <= 1'b0;
			w_got_q   <= 1'b0;
			r_valid_q <= 1'b0;
			b_valid_q <= 1'b0;
		end else begin
			if (ch_hs[0])
				r_valid_q <= 1'b1;
			else if (r_ready_i)
				r_valid_q <= 1'b0;
			if (ch_hs[1])
				aw_got_q <= 1'b1;
			if (ch_hs[2])
				w_got_q <= 1'b1;
			// answer on B the cycle after both halves are in
			if (do_write) begin
				aw_got_q  <= 1'b0;
				w_got_q   <= 1'b0;
				b_valid_q <= 1'b1;
			end else if (b_ready_i) begin
				b_valid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ch_hs[0]) begin
			r_data_q <= rd_in_range ? mem[ar_addr_i[MEM_IDX_W+1:2]] : '0;
			r_resp_q <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
		end
		if (ch_hs[1])
			aw_addr_q <= aw_addr_i;
		if (ch_hs[2]) begin
			w_data_q <= w_data_i;
			w_strb_q <= w_strb_i;
		end
		if (do_write)
			b_resp_q <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
	end

	always_ff @(posedge clk) begin
		if (rstn) begin
			for (int i = 0; i < MEM_WORDS; i++)
				mem[i] <= '0;
		end else if (do_write && wr_in_range) begin
			for (int b = 0; b < STRB_W; b++) begin
				if (w_strb_q[b])
					mem[aw_addr_q[MEM_IDX_W+1:2]][8*b +: 8] <= w_data_q[8*b +: 8];
			end
		end
	end

	assign r_valid_o = r_valid_q;
	assign r_data_o  = r_data_q;
	assign r_resp_o  = r_resp_q;
	assign b_valid_o = b_valid_q;
	assign b_resp_o  = b_resp_q;

	// master holds off AR until the pending read response is taken
	ar_while_r_pending: assert property (@(posedge clk) disable iff (rstn)
		r_valid_o |-> !ar_valid_i);

endmodule

/* rtl/lsu_top.sv */
/*
 * load/store unit top level
 * controller as AXI4-Lite master wired to the slave word memory
 */
`timescale 1ns/100ps

module lsu_top (
	input  logic                            clk,
	input  logic                            rstn,
	input  logic                            req_valid_i,
	input  lsu_pkg::mem_op_e                req_op_i,
	input  logic [lsu_pkg::ADDR_W-1:0]      req_addr_i,
	input  logic [lsu_pkg::DATA_W-1:0]      req_wdata_i,
	input  logic [lsu_pkg::REG_W-1:0]       req_rd_i,
	output logic                            req_ready_o,
	output logic                            resp_valid_o,
	output logic [lsu_pkg::REG_W-1:0]       resp_rd_o,
	output logic [lsu_pkg::DATA_W-1:0]      resp_data_o,
	output logic                            resp_err_o
);
	import lsu_pkg::*;

	// AXI4-Lite bus between master and slave
	logic [ADDR_W-1:0] ar_addr, aw_addr;
	logic [DATA_W-1:0] r_data, w_data;
	logic [STRB_W-1:0] w_strb;
	resp_e             r_resp, b_resp;
	logic              ar_valid, ar_ready, r_valid, r_ready;
	logic              aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;

	lsu_ctrl u_lsu_ctrl (
		.clk          (clk),
		.rstn         (rstn),
		.req_valid_i  (req_valid_i),
		.req_op_i     (req_op_i),
		.req_addr_i   (req_addr_i),
		.req_wdata_i  (req_wdata_i),
		.req_rd_i     (req_rd_i),
		.req_ready_o  (req_ready_o),
		.ar_addr_o    (ar_addr),
		.ar_valid_o   (ar_valid),
		.ar_ready_i   (ar_ready),
		.r_data_i     (r_data),
		.r_resp_i     (r_resp),
		.r_valid_i    (r_valid),
		.r_ready_o    (r_ready),
		.aw_addr_o    (aw_addr),
		.aw_valid_o   (aw_valid),
		.aw_ready_i   (aw_ready),
		.w_data_o     (w_data),
		.w_strb_o     (w_strb),
		.w_valid_o    (w_valid),
		.w_ready_i    (w_ready),
		.b_resp_i     (b_resp),
		.b_valid_i    (b_valid),
		.b_ready_o    (b_ready),
		.resp_valid_o (resp_valid_o),
		.resp_rd_o    (resp_rd_o),
		.resp_data_o  (resp_data_o),
		.resp_err_o   (resp_err_o)
	);

	axi_sram u_axi_sram (
		.clk        (clk),
		.rstn       (rstn),
		.ar_addr_i  (ar_addr),
		.ar_valid_i (ar_valid),
		.ar_ready_o (ar_ready),
		.r_data_o   (r_data),
		.r_resp_o   (r_resp),
		.r_valid_o  (r_valid),
		.r_ready_i  (r_ready),
		.aw_addr_i  (aw_addr),
		.aw_valid_i (aw_valid),
		.aw_ready_o (aw_ready),
		.w_data_i   (w_data),
		.w_strb_i   (w_strb),
		.w_valid_i  (w_valid),
		.w_ready_o  (w_ready),
		.b_resp_o   (b_resp),
		.b_valid_o  (b_valid),
		.b_ready_i  (b_ready)
	);

endmodule

/* testbench/tb_clkgen.sv */
/*
 * testbench clock source
 * free running clock, 40 ns period by default
 */
`timescale 1ns/100ps

module tb_clkgen #(
	parameter int PERIOD_NS = 40
) (
	output logic clk_o
);

	initial clk_o = 1'b0;

	always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

/* testbench/lsu_tb.sv */
/*
 * load/store unit testbench
 * directed tests against a byte-array model of the AXI4-Lite memory,
 * followed by seeded random traffic, with a watchdog on the run time
 */
`timescale 1ns/100ps

module lsu_tb;
	import lsu_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int CLK_NS       = 40;
	localparam int RAND_OPS     = 40;
	// requests per test: pass-through, round trip, partial, extension, range
	localparam int REQ_TOTAL    = 2 + 4 + 10 + 26 + 4 + RAND_OPS;
	localparam int WATCHDOG_NS  = (RESET_CYCLES + REQ_TOTAL * 20) * CLK_NS;
	localparam int MEM_BYTES    = MEM_WORDS * 4;

	logic              clk;
	logic              rstn;
	logic              req_valid;
	mem_op_e           req_op;
	logic [ADDR_W-1:0] req_addr;
	logic [DATA_W-1:0] req_wdata;
	logic [REG_W-1:0]  req_rd;
	logic              req_ready;
	logic              resp_valid;
	logic [REG_W-1:0]  resp_rd;
	logic [DATA_W-1:0] resp_data;
	logic              resp_err;

	logic [7:0]        model_mem [MEM_BYTES];
	integer            seed;

	tb_clkgen #(.PERIOD_NS(CLK_NS)) u_tb_clkgen (.clk_o(clk));

	lsu_top u_lsu_top (
		.clk          (clk),
		.rstn         (rstn),
		.req_valid_i  (req_valid),
		.req_op_i     (req_op),
		.req_addr_i   (req_addr),
		.req_wdata_i  (req_wdata),
		.req_rd_i     (req_rd),
		.req_ready_o  (req_ready),
		.resp_valid_o (resp_valid),
		.resp_rd_o    (resp_rd),
		.resp_data_o  (resp_data),
		.resp_err_o   (resp_err)
	);

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_val(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAIL %s: expected %08h, actual %08h", name, expected, actual);
			$display("TEST RESULT: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic logic is_load_op(input mem_op_e op);
		case (op)
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic is_store_op(input mem_op_e op);
		case (op)
			OP_SB, OP_SH, OP_SW: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic in_range(input logic [31:0] addr);
		return addr < 32'(MEM_BYTES);
	endfunction

	// little endian byte model of the slave memory
	task automatic model_store(input mem_op_e op, input logic [31:0] addr,
			input logic [31:0] data);
		int a;
		if (in_range(addr)) begin
			a = int'(addr);
			model_mem[a] = data[7:0];
			if (op == OP_SH || op == OP_SW)
				model_mem[a + 1] = data[15:8];
			if (op == OP_SW) begin
				model_mem[a + 2] = data[23:16];
				model_mem[a + 3] = data[31:24];
			end
		end
	endtask

	function automatic logic [31:0] model_load(input mem_op_e op, input logic [31:0] addr);
		int a;
		if (!in_range(addr))
			return 32'd0;
		a = int'(addr);
		case (op)
			OP_LB:  return {{24{model_mem[a][7]}}, model_mem[a]};
			OP_LBU: return {24'd0, model_mem[a]};
			OP_LH:  return {{16{model_mem[a + 1][7]}}, model_mem[a + 1], model_mem[a]};
			OP_LHU: return {16'd0, model_mem[a + 1], model_mem[a]};
			OP_LW:  return {model_mem[a + 3], model_mem[a + 2], model_mem[a + 1], model_mem[a]};
			default: return 32'd0;
		endcase
	endfunction

	function automatic logic [31:0] expected_data(input mem_op_e op, input logic [31:0] addr);
		if (is_load_op(op))
			return model_load(op, addr);
		else if (is_store_op(op))
			return 32'd0;
		return addr;
	endfunction

	// one handshake, then wait for the result pulse; lat counts from acceptance
	task automatic issue_request(input mem_op_e op, input logic [31:0] addr,
			input logic [31:0] wdata, input logic [4:0] rd, output logic [31:0] data,
			output logic [4:0] got_rd, output logic err, output int lat);
		@(posedge clk);
		req_valid <= 1'b1;
		req_op    <= op;
		req_addr  <= addr;
		req_wdata <= wdata;
		req_rd    <= rd;
		@(negedge clk);
		while (!req_ready)
			@(negedge clk);
		@(posedge clk);
		req_valid <= 1'b0;
		lat = 0;
		do begin
			@(negedge clk);
			lat++;
		end while (!resp_valid);
		data   = resp_data;
		got_rd = resp_rd;
		err    = resp_err;
	endtask

	task automatic run_op(input string name, input mem_op_e op, input logic [31:0] addr,
			input logic [31:0] wdata, input logic [4:0] rd);
		logic [31:0] exp_data;
		logic        exp_err;
		logic [31:0] data;
		logic [4:0]  got_rd;
		logic        err;
		int          lat;
		exp_data = expected_data(op, addr);
		exp_err  = (is_load_op(op) || is_store_op(op)) && !in_range(addr);
		issue_request(op, addr, wdata, rd, data, got_rd, err, lat);
		check_val({name, " data"}, exp_data, data);
		check_val({name, " err"}, 32'(exp_err), 32'(err));
		check_val({name, " rd"}, 32'(rd), 32'(got_rd));
		if (op == OP_NONE)
			check_val({name, " latency"}, 32'd1, 32'(lat));
		else if (lat < 3)
			stop_with_error($sformatf("%s finished only %0d cycles after acceptance", name, lat));
		if (is_store_op(op))
			model_store(op, addr, wdata);
	endtask

	task automatic test_reset_state();
		check_val("reset_state req_ready", 32'd1, 32'(req_ready));
		check_val("reset_state resp_valid", 32'd0, 32'(resp_valid));
	endtask

	task automatic test_pass_through();
		run_op("pass_through a", OP_NONE, 32'h1234_5678, 32'hffff_ffff, 5'd7);
		run_op("pass_through b", OP_NONE, 32'h8000_0003, 32'd0, 5'd31);
	endtask

	task automatic test_word_round_trip();
		run_op("round_trip sw 10", OP_SW, 32'h10, 32'hdead_beef, 5'd1);
		run_op("round_trip lw 10", OP_LW, 32'h10, 32'd0, 5'd2);
		// last word of the memory
		run_op("round_trip sw 3fc", OP_SW, 32'h3fc, 32'h0bad_cafe, 5'd3);
		run_op("round_trip lw 3fc", OP_LW, 32'h3fc, 32'd0, 5'd4);
	endtask

	task automatic test_partial_stores();
		for (int lane = 0; lane < 4; lane++)
			run_op($sformatf("partial sb lane %0d", lane), OP_SB, 32'h40 + 32'(lane),
				32'h5a00_0011 + 32'(lane * 17), 5'(lane + 8));
		run_op("partial lw 40", OP_LW, 32'h40, 32'd0, 5'd12);
		run_op("partial sw 44", OP_SW, 32'h44, 32'hffff_ffff, 5'd13);
		run_op("partial sh 44", OP_SH, 32'h44, 32'h9999_1234, 5'd14);
		run_op("partial lw 44 low", OP_LW, 32'h44, 32'd0, 5'd15);
		run_op("partial sh 46", OP_SH, 32'h46, 32'h0000_abcd, 5'd16);
		run_op("partial lw 44 high", OP_LW, 32'h44, 32'd0, 5'd17);
	endtask

	task automatic test_load_extension();
		logic [31:0] base;
		run_op("extension sw 80", OP_SW, 32'h80, 32'h80ff_7f01, 5'd18);
		run_op("extension sw 84", OP_SW, 32'h84, 32'h7fff_8000, 5'd19);
		for (int w = 0; w < 2; w++) begin
			base = 32'h80 + 32'(w * 4);
			for (int lane = 0; lane < 4; lane++) begin
				run_op($sformatf("extension lb %0h", base + 32'(lane)), OP_LB,
					base + 32'(lane), 32'd0, 5'd20);
				run_op($sformatf("extension lbu %0h", base + 32'(lane)), OP_LBU,
					base + 32'(lane), 32'd0, 5'd21);
			end
			for (int lane = 0; lane < 4; lane += 2) begin
				run_op($sformatf("extension lh %0h", base + 32'(lane)), OP_LH,
					base + 32'(lane), 32'd0, 5'd22);
				run_op($sformatf("extension lhu %0h", base + 32'(lane)), OP_LHU,
					base + 32'(lane), 32'd0, 5'd23);
			end
		end
	endtask

	task automatic test_range_and_random();
		logic [31:0] pick;
		logic [31:0] addr;
		logic [3:0]  code;
		mem_op_e     op;
		run_op("range lw", OP_LW, 32'(MEM_BYTES), 32'd0, 5'd24);
		run_op("range sw", OP_SW, 32'(MEM_BYTES) + 32'd4, 32'h1357_9bdf, 5'd25);
		run_op("range lb", OP_LB, 32'hffff_fff1, 32'd0, 5'd26);
		run_op("range lhu", OP_LHU, 32'h0000_1002, 32'd0, 5'd27);
		seed = 75;
		for (int n = 0; n < RAND_OPS; n++) begin
			pick = $random(seed);
			// OP_LB up to OP_SW
			code = {1'b0, pick[2:0]} + 4'd1;
			op   = mem_op_e'(code);
			addr = $random(seed);
			addr = addr & (32'(MEM_BYTES) - 32'd1);
			if (op == OP_LH || op == OP_LHU || op == OP_SH)
				addr[0] = 1'b0;
			if (op == OP_LW || op == OP_SW)
				addr[1:0] = 2'b00;
			run_op($sformatf("random %0d %s", n, op.name()), op, addr, $random(seed),
				pick[8:4]);
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the DUT stopped responding", WATCHDOG_NS);
		$display("TEST RESULT: FAIL");
		$fatal(1, "timeout");
	end

	initial begin
		rstn      = 1'b1;
		req_valid = 1'b0;
		req_op    = OP_NONE;
		req_addr  = '0;
		req_wdata = '0;
		req_rd    = '0;
		// memory comes out of reset cleared
		for (int i = 0; i < MEM_BYTES; i++)
			model_mem[i] = 8'd0;
		repeat (RESET_CYCLES) @(posedge clk);
		rstn <= 1'b0;
		@(negedge clk);
		test_reset_state();
		test_pass_through();
		test_word_round_trip();
		test_partial_stores();
		test_load_extension();
		test_range_and_random();
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* verilog.f */
rtl/lsu_pkg.sv
rtl/mem_align.sv
rtl/lsu_ctrl.sv
rtl/axi_sram.sv
rtl/lsu_top.sv
testbench/tb_clkgen.sv
testbench/lsu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the load/store unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f verilog.f \
	--top-module lsu_tb \
	-o lsu_sim

# the simulation exits non-zero on failure, the log decides the result
./obj_dir/lsu_sim 2>&1 | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
